// ==== Bender.yml ====
package:
  name: fdiv

sources:
  - design/fdiv_pkg.sv
  - design/fdiv_op_if.sv
  - design/fraction_normalizer.sv
  - design/fdiv_operand_stage.sv
  - design/newton_divider.sv
  - design/fdiv_round_pack.sv
  - design/fdiv_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/fdiv_tb.sv

// ==== build.f ====
+incdir+sim
design/fdiv_pkg.sv
design/fdiv_op_if.sv
design/fraction_normalizer.sv
design/fdiv_operand_stage.sv
design/newton_divider.sv
design/fdiv_round_pack.sv
design/fdiv_top.sv
sim/fdiv_tb.sv

// ==== design/fdiv_op_if.sv ====
interface fdiv_op_if;
    import fdiv_pkg::*;

    logic              op_valid;    // one cycle, operands just captured
    logic [SIG_W-1:0]  a_sig;       // normalized, msb set unless zero
    logic [SIG_W-1:0]  b_sig;
    logic [XEXP_W-1:0] exp_diff;    // biased result exponent, two's complement
    logic              sign;        // xor of operand signs
    logic [1:0]        rm;

    // operand classes
    logic a_exp_zero;
    logic a_exp_ones;
    logic a_frac_zero;
    logic b_exp_zero;
    logic b_exp_ones;
    logic b_frac_zero;

    modport producer (
        output op_valid, a_sig, b_sig, exp_diff, sign, rm,
        output a_exp_zero, a_exp_ones, a_frac_zero,
        output b_exp_zero, b_exp_ones, b_frac_zero
    );

    modport divider (input op_valid, a_sig, b_sig);

    modport packer (
        input exp_diff, sign, rm,
        input a_exp_zero, a_exp_ones, a_frac_zero,
        input b_exp_zero, b_exp_ones, b_frac_zero
    );

endinterface

// ==== design/fdiv_operand_stage.sv ====
module fdiv_operand_stage (
    input  logic            clk,
    input  logic            clrn,
    input  logic            start,
    input  logic            busy,
    input  fdiv_pkg::fp32_u a,
    input  fdiv_pkg::fp32_u b,
    input  logic [1:0]      rm,
    fdiv_op_if.producer     op
);
    import fdiv_pkg::*;

    fp32_u            a_q;      // captured dividend
    fp32_u            b_q;      // captured divisor
    logic             accept;
    logic [SIG_W-1:0] a_pre;    // significand before leading one search
    logic [SIG_W-1:0] b_pre;
    logic [4:0]       a_shift;
    logic [4:0]       b_shift;

    assign accept = start & ~busy;  // starts during a division are dropped

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            op.op_valid <= 1'b0;
        end else begin
            op.op_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q   <= a;
            b_q   <= b;
            op.rm <= rm;
        end
    end

    // classification of the held words
    assign op.a_exp_zero  = ~|a_q.f.expo;
    assign op.a_exp_ones  = &a_q.f.expo;
    assign op.a_frac_zero = ~|a_q.f.frac;
    assign op.b_exp_zero  = ~|b_q.f.expo;
    assign op.b_exp_ones  = &b_q.f.expo;
    assign op.b_frac_zero = ~|b_q.f.frac;
    assign op.sign        = a_q.f.sign ^ b_q.f.sign;

    // denormals have no hidden one, their exponent acts as 1
    assign a_pre = op.a_exp_zero ? {a_q.f.frac, 1'b0} : {1'b1, a_q.f.frac};
    assign b_pre = op.b_exp_zero ? {b_q.f.frac, 1'b0} : {1'b1, b_q.f.frac};

    fraction_normalizer i_norm_a (
        .sig_in  (a_pre),
        .sig_out (op.a_sig),
        .shift   (a_shift)
    );

    fraction_normalizer i_norm_b (
        .sig_in  (b_pre),
        .sig_out (op.b_sig),
        .shift   (b_shift)
    );

    // ea - eb + bias, corrected by the normalization shifts
    assign op.exp_diff = XEXP_W'(a_q.f.expo) - XEXP_W'(b_q.f.expo) + XEXP_W'(EXP_BIAS)
                       - XEXP_W'(a_shift) + XEXP_W'(b_shift);

endmodule

// ==== design/fdiv_pkg.sv ====
package fdiv_pkg;

    // ieee 754 single precision layout
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int SIG_W    = 24;      // fraction plus hidden one
    localparam int EXP_BIAS = 127;

    // internal datapath widths
    localparam int XEXP_W  = 10;       // signed, room for under/overflow
    localparam int RECIP_W = 26;       // reciprocal estimate, 2.24 fixed point
    localparam int QUO_W   = 32;       // raw quotient, lsb is sticky

    // result patterns without the sign bit
    localparam logic [30:0] QNAN_PAT       = 31'h7fc0_0000;
    localparam logic [30:0] INF_PAT        = 31'h7f80_0000;
    localparam logic [30:0] MAX_FINITE_PAT = 31'h7f7f_ffff;
    localparam logic [30:0] ZERO_PAT       = 31'h0000_0000;

    // rounding modes
    localparam logic [1:0] RM_NEAREST = 2'b00;  // nearest, ties to even
    localparam logic [1:0] RM_DOWN    = 2'b01;  // toward minus infinity
    localparam logic [1:0] RM_UP      = 2'b10;  // toward plus infinity
    localparam logic [1:0] RM_ZERO    = 2'b11;  // truncate

    // one float word, seen raw or split into fields
    typedef union packed {
        logic [EXP_W+FRAC_W:0] bits;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  expo;
            logic [FRAC_W-1:0] frac;
        } f;
    } fp32_u;

endpackage

// ==== design/fdiv_round_pack.sv ====
module fdiv_round_pack (
    input  logic                       clk,
    input  logic                       clrn,
    fdiv_op_if.packer                  op,
    input  logic [fdiv_pkg::QUO_W-1:0] quo,
    input  logic                       quo_valid,
    output fdiv_pkg::fp32_u            s,
    output logic                       done
);
    import fdiv_pkg::*;

    logic signed [XEXP_W-1:0] exp_in;
    logic signed [XEXP_W-1:0] exp_adj;     // after quotient normalization
    logic signed [XEXP_W-1:0] exp0;        // zero for denormals
    logic signed [XEXP_W-1:0] exp1;        // after rounding carry
    logic [XEXP_W-1:0]        den_shamt;
    logic [4:0]               den_sh;
    logic [QUO_W-1:0]         z0;
    logic [QUO_W-1:0]         frac0;
    logic [SIG_W-1:0]         sig;
    logic                     guard;
    logic                     sticky;
    logic                     inc;
    logic [SIG_W:0]           sig_rnd;
    logic                     ovf;
    logic [30:0]              ovf_pat;
    logic                     a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
    fp32_u                    res;

    assign exp_in = op.exp_diff;

    // raw quotient lies in [0.5,2), bring to 1.xxx
    assign z0      = quo[QUO_W-1] ? quo : {quo[QUO_W-2:0], 1'b0};
    assign exp_adj = quo[QUO_W-1] ? exp_in : exp_in - XEXP_W'(1);

    // right shift for the denormal range, clamped, result stays nonzero
    assign den_shamt = XEXP_W'(1) - exp_adj;
    assign den_sh    = (den_shamt > XEXP_W'(31)) ? 5'd31 : den_shamt[4:0];

    always_comb begin
        if (exp_adj <= 0) begin
            exp0  = '0;
            frac0 = (z0 >> den_sh) | QUO_W'(|(z0 & ~({QUO_W{1'b1}} << den_sh)));
        end else begin
            exp0  = exp_adj;
            frac0 = z0;
        end
    end

    assign sig    = frac0[QUO_W-1 -: SIG_W];
    assign guard  = frac0[QUO_W-SIG_W-1];
    assign sticky = |frac0[QUO_W-SIG_W-2:0];

    always_comb begin
        inc = 1'b0;
        case (op.rm)
            RM_NEAREST: inc = guard & (sticky | sig[0]);   // tie goes to even
            RM_DOWN:    inc = (guard | sticky) & op.sign;
            RM_UP:      inc = (guard | sticky) & ~op.sign;
            RM_ZERO:    inc = 1'b0;
        endcase
    end

    assign sig_rnd = {1'b0, sig} + inc;

    always_comb begin
        if (sig_rnd[SIG_W]) begin
            exp1 = exp0 + XEXP_W'(1);       // 1.11..1 rounded up to 10.0
        end else if (exp0 == 0 && sig_rnd[SIG_W-1]) begin
            exp1 = XEXP_W'(1);              // largest denormal became normal
        end else begin
            exp1 = exp0;
        end
    end

    assign ovf = (exp1 > 254);

    // saturation value for each mode
    always_comb begin
        ovf_pat = INF_PAT;
        case (op.rm)
            RM_NEAREST: ovf_pat = INF_PAT;
            RM_DOWN:    ovf_pat = op.sign ? INF_PAT : MAX_FINITE_PAT;
            RM_UP:      ovf_pat = op.sign ? MAX_FINITE_PAT : INF_PAT;
            RM_ZERO:    ovf_pat = MAX_FINITE_PAT;
        endcase
    end

    assign a_nan  = op.a_exp_ones & ~op.a_frac_zero;
    assign b_nan  = op.b_exp_ones & ~op.b_frac_zero;
    assign a_inf  = op.a_exp_ones & op.a_frac_zero;
    assign b_inf  = op.b_exp_ones & op.b_frac_zero;
    assign a_zero = op.a_exp_zero & op.a_frac_zero;
    assign b_zero = op.b_exp_zero & op.b_frac_zero;

    // special operands take priority over the computed value
    always_comb begin
        res.f.sign = op.sign;
        res.f.expo = exp1[EXP_W-1:0];
        res.f.frac = sig_rnd[FRAC_W-1:0];
        if (a_nan | b_nan | (a_zero & b_zero) | (a_inf & b_inf)) begin
            res.bits = {1'b0, QNAN_PAT};        // nan is unsigned
        end else if (a_inf | b_zero) begin
            {res.f.expo, res.f.frac} = INF_PAT;
        end else if (a_zero | b_inf) begin
            {res.f.expo, res.f.frac} = ZERO_PAT;
        end else if (ovf) begin
            {res.f.expo, res.f.frac} = ovf_pat;
        end
    end

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            s    <= '0;
            done <= 1'b0;
        end else begin
            done <= quo_valid;
            if (quo_valid) begin
                s <= res;
            end
        end
    end

endmodule

// ==== design/fdiv_top.sv ====
module fdiv_top #(
    parameter int NR_ITER = 3      // refinement steps, 2 to 4
) (
    input  logic        clk,
    input  logic        clrn,
    input  logic        start,
    input  logic [31:0] a,         // dividend
    input  logic [31:0] b,         // divisor
    input  logic [1:0]  rm,
    output logic [31:0] s,         // quotient, held until next done
    output logic        done,
    output logic        busy
);
    import fdiv_pkg::*;

    logic [QUO_W-1:0] quo;         // raw quotient with sticky
    logic             quo_valid;

    fdiv_op_if op_bus ();

    fdiv_operand_stage i_operand_stage (
        .clk   (clk),
        .clrn  (clrn),
        .start (start),
        .busy  (busy),
        .a     (a),
        .b     (b),
        .rm    (rm),
        .op    (op_bus.producer)
    );

    newton_divider #(
        .NR_ITER (NR_ITER)
    ) i_newton_divider (
        .clk       (clk),
        .clrn      (clrn),
        .op        (op_bus.divider),
        .quo       (quo),
        .quo_valid (quo_valid),
        .busy      (busy)
    );

    fdiv_round_pack i_round_pack (
        .clk       (clk),
        .clrn      (clrn),
        .op        (op_bus.packer),
        .quo       (quo),
        .quo_valid (quo_valid),
        .s         (s),
        .done      (done)
    );

endmodule

// ==== design/fraction_normalizer.sv ====
module fraction_normalizer (
    input  logic [fdiv_pkg::SIG_W-1:0] sig_in,
    output logic [fdiv_pkg::SIG_W-1:0] sig_out,
    output logic [4:0]                 shift
);
    import fdiv_pkg::*;

    logic [SIG_W-1:0] s16;  // after the 16 bit step
    logic [SIG_W-1:0] s8;
    logic [SIG_W-1:0] s4;
    logic [SIG_W-1:0] s2;

    // each level tests the top bits and shifts by its weight
    assign shift[4] = ~|sig_in[SIG_W-1 -: 16];
    assign s16      = shift[4] ? {sig_in[SIG_W-17:0], 16'b0} : sig_in;

    assign shift[3] = ~|s16[SIG_W-1 -: 8];
    assign s8       = shift[3] ? {s16[SIG_W-9:0], 8'b0} : s16;

    assign shift[2] = ~|s8[SIG_W-1 -: 4];
    assign s4       = shift[2] ? {s8[SIG_W-5:0], 4'b0} : s8;

    assign shift[1] = ~|s4[SIG_W-1 -: 2];
    assign s2       = shift[1] ? {s4[SIG_W-3:0], 2'b0} : s4;

    // last single bit, all zero input ends at shift 31
    assign shift[0] = ~s2[SIG_W-1];
    assign sig_out  = shift[0] ? {s2[SIG_W-2:0], 1'b0} : s2;

endmodule

// ==== design/newton_divider.sv ====
module newton_divider #(
    parameter int NR_ITER = 3
) (
    input  logic                       clk,
    input  logic                       clrn,
    fdiv_op_if.divider                 op,
    output logic [fdiv_pkg::QUO_W-1:0] quo,
    output logic                       quo_valid,
    output logic                       busy
);
    import fdiv_pkg::*;

    localparam int CNT_W = $clog2(2 * NR_ITER + 1);
    localparam int PRD_W = SIG_W + RECIP_W;  // significand times estimate

    logic                   run;        // refinement or final multiply pending
    logic [CNT_W-1:0]       cnt;        // half-iteration counter
    logic                   last;
    logic [7:0]             seed;
    logic [RECIP_W-1:0]     x_r;        // estimate of 1/b, 2.24
    logic [RECIP_W-1:0]     bx_r;       // b*x, 1.25
    logic [RECIP_W-1:0]     two_minus;  // 2 - b*x
    logic [PRD_W-1:0]       bx_full;
    logic [2*RECIP_W-1:0]   x_next;
    logic [PRD_W-1:0]       ax_full;

    assign last = (cnt == CNT_W'(2 * NR_ITER));

    // seed table, indexed by the four divisor bits under the leading one
    always_comb begin
        case (op.b_sig[SIG_W-2 -: 4])
            4'h0: seed = 8'hff;
            4'h1: seed = 8'hdf;
            4'h2: seed = 8'hc3;
            4'h3: seed = 8'haa;
            4'h4: seed = 8'h93;
            4'h5: seed = 8'h7f;
            4'h6: seed = 8'h6d;
            4'h7: seed = 8'h5c;
            4'h8: seed = 8'h4d;
            4'h9: seed = 8'h3f;
            4'ha: seed = 8'h33;
            4'hb: seed = 8'h27;
            4'hc: seed = 8'h1c;
            4'hd: seed = 8'h12;
            4'he: seed = 8'h08;
            default: seed = 8'h00;
        endcase
    end

    assign bx_full   = op.b_sig * x_r;
    assign two_minus = ~bx_r + 1'b1;      // two's complement, mod 2
    assign x_next    = x_r * two_minus;    // 3.49 result
    assign ax_full   = op.a_sig * x_r;     // quotient, 2.48

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            run       <= 1'b0;
            cnt       <= '0;
            quo_valid <= 1'b0;
        end else begin
            quo_valid <= 1'b0;
            if (op.op_valid) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                if (last) begin
                    run       <= 1'b0;
                    quo_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.op_valid) begin
            x_r <= {2'b01, seed, {(RECIP_W - 10){1'b0}}};
        end else if (run && !last) begin
            if (!cnt[0]) begin
                bx_r <= bx_full[PRD_W-2 -: RECIP_W];     // even step: b*x
            end else begin
                x_r <= x_next[2*RECIP_W-2 -: RECIP_W];  // odd step: x*(2-b*x)
            end
        end
        if (run && last) begin
            quo <= {ax_full[PRD_W-2 -: QUO_W-1], |ax_full[PRD_W-QUO_W-1:0]};
        end
    end

    // covers the capture cycle through the quo_valid cycle
    assign busy = op.op_valid | run | quo_valid;

endmodule

// ==== sim/fdiv_model.svh ====
`ifndef FDIV_MODEL_SVH
`define FDIV_MODEL_SVH

// magnitude of a finite float as a real
function automatic real operand_value(input logic [31:0] w);
    real v;
    int  e;
    int  i;
    v = w[22:0];
    if (w[30:23] != 8'h00) begin
        v = v + 8388608.0;               // hidden one
    end
    e = (w[30:23] == 8'h00) ? -149 : int'(w[30:23]) - 150;
    for (i = 0; i < e; i++) v = v * 2.0;
    for (i = 0; i < -e; i++) v = v / 2.0;
    return v;
endfunction

// nan, infinite or zero operand on either side
function automatic bit is_special(input logic [31:0] x, input logic [31:0] y);
    return (x[30:23] == 8'hff) || (x[30:0] == 31'h0) ||
           (y[30:23] == 8'hff) || (y[30:0] == 31'h0);
endfunction

function automatic logic [31:0] special_result(input logic [31:0] x, input logic [31:0] y);
    bit x_nan, y_nan, x_inf, y_inf, x_zero, y_zero;
    x_nan  = (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
    y_nan  = (y[30:23] == 8'hff) && (y[22:0] != 23'h0);
    x_inf  = (x[30:0] == 31'h7f80_0000);
    y_inf  = (y[30:0] == 31'h7f80_0000);
    x_zero = (x[30:0] == 31'h0);
    y_zero = (y[30:0] == 31'h0);
    if (x_nan || y_nan || (x_zero && y_zero) || (x_inf && y_inf)) begin
        return 32'h7fc0_0000;            // quiet nan, no sign
    end
    if (x_inf || y_zero) return {x[31] ^ y[31], 31'h7f80_0000};
    return {x[31] ^ y[31], 31'h0};       // zero dividend or infinite divisor
endfunction

// correctly rounded x/y, bit 32 flags a quotient far above the finite range
function automatic logic [32:0] rounded_quotient(input logic [31:0] x, input logic [31:0] y,
                                                 input logic [1:0] mode);
    real    q;
    real    scaled;
    real    rem;
    int     e;
    int     i;
    int     biased;
    longint ip;
    longint mag;
    bit     neg;
    bit     inc;
    bit     away;
    neg = x[31] ^ y[31];
    q   = operand_value(x) / operand_value(y);
    e   = 0;
    while (q >= 2.0) begin
        q = q / 2.0;
        e++;
    end
    while (q < 1.0) begin
        q = q * 2.0;
        e--;
    end
    biased = e + 127;
    scaled = q * 8388608.0;              // units of one ulp for normals
    for (i = biased; i < 1; i++) scaled = scaled / 2.0;  // align to the denormal grid
    ip  = $rtoi(scaled);
    rem = scaled - ip;
    case (mode)
        2'b00:   inc = (rem > 0.5) || ((rem == 0.5) && ip[0]);  // ties to even
        2'b01:   inc = (rem > 0.0) && neg;                      // toward -inf
        2'b10:   inc = (rem > 0.0) && !neg;                     // toward +inf
        default: inc = 1'b0;                                    // truncate
    endcase
    ip  = ip + inc;
    mag = (biased >= 1) ? (longint'(biased - 1) << 23) + ip : ip;  // carry lands in exponent
    if (mag >= 64'h7f80_0000) begin
        away = (mode == 2'b00) || ((mode == 2'b10) && !neg) || ((mode == 2'b01) && neg);
        mag  = away ? 64'h7f80_0000 : 64'h7f7f_ffff;
    end
    return {biased >= 256, neg, mag[30:0]};
endfunction

// distance in representable steps, large when the signs differ
function automatic int ulp_distance(input logic [31:0] x, input logic [31:0] y);
    int d;
    if (x[31] != y[31]) return 1 << 30;
    d = int'(x[30:0]) - int'(y[30:0]);
    return (d < 0) ? -d : d;
endfunction

`endif

// ==== sim/fdiv_tb.sv ====
module fdiv_tb;
    `include "fdiv_model.svh"

    localparam int          NR_ITER   = 3;
    localparam int          LATENCY   = 3 + 2 * NR_ITER;   // sampled start edge to done
    localparam int          N_OPS     = 400;
    localparam int          OP_CYCLES = 2 * LATENCY + 10;  // worst op, drop watch and idle included
    localparam int unsigned SEED      = 32'h10c4_85fb;

    logic        clk;
    logic        clrn;
    logic        start;
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  rm;
    logic [31:0] s;
    logic        done;
    logic        busy;

    int          n_checks;
    int          n_err_val;       // wrong result or reset value
    int          n_err_lat;       // wrong done timing
    int          n_err_proto;     // busy/done misbehavior
    int          op_idx;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [1:0]  op_rm;
    bit          drop;

    fdiv_top #(
        .NR_ITER (NR_ITER)
    ) i_fdiv_top (
        .clk   (clk),
        .clrn  (clrn),
        .start (start),
        .a     (a),
        .b     (b),
        .rm    (rm),
        .s     (s),
        .done  (done),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(N_OPS * OP_CYCLES * 20 + 2000);
        $display("watchdog expired, the DUT stopped finishing divisions");
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] make_operand(input int kind);
        logic        sgn;
        logic [7:0]  e;
        logic [22:0] f;
        sgn = 1'($urandom);
        f   = 23'($urandom);
        case (kind)
            0: e = 8'(100 + $urandom % 56);     // moderate normal
            1: begin
                e    = 8'h00;                   // denormal
                f[0] = 1'b1;
            end
            2: begin
                e = 8'h00;                      // zero
                f = '0;
            end
            3: begin
                e = 8'hff;                      // infinity
                f = '0;
            end
            4: begin
                e    = 8'hff;                   // nan
                f[0] = 1'b1;
            end
            5: e = 8'(230 + $urandom % 25);     // huge
            6: e = 8'(1 + $urandom % 25);       // tiny normal
            default: e = 8'($urandom);          // any word
        endcase
        return {sgn, e, f};
    endfunction

    task automatic pick_operands(output logic [31:0] x, output logic [31:0] y);
        int sel;
        sel = int'($urandom % 16);
        case (sel)
            0, 1, 2, 3, 4, 5, 6: begin
                x = make_operand(0);
                y = make_operand(0);
            end
            7: begin
                x = make_operand(1);
                y = make_operand(0);
            end
            8: begin
                x = make_operand(0);
                y = make_operand(1);
            end
            9: begin
                x = make_operand(2 + int'($urandom % 3));   // special dividend
                y = make_operand(int'($urandom % 5));
            end
            10: begin
                x = make_operand(int'($urandom % 5));
                y = make_operand(2 + int'($urandom % 3));  // special divisor
            end
            11: begin
                x = make_operand(5);            // overflow pair
                y = make_operand(6);
            end
            12: begin
                x = make_operand(6);            // underflow pair
                y = make_operand(5);
            end
            13: begin
                x = make_operand(1);            // deep underflow
                y = make_operand(5);
            end
            default: begin
                x = make_operand(7);
                y = make_operand(7);
            end
        endcase
    endtask

    task automatic check_result(input logic [31:0] x, input logic [31:0] y,
                                input logic [1:0] mode);
        logic [32:0] model;
        logic [31:0] expected;
        string       name;
        int          tol;
        n_checks++;
        if (is_special(x, y)) begin
            expected = special_result(x, y);
            name     = "special_cases";
            tol      = 0;
        end else begin
            model    = rounded_quotient(x, y, mode);
            expected = model[31:0];
            name     = model[32] ? "overflow_saturation" : "normal_quotient";
            tol      = model[32] ? 0 : 1;              // far overflow must saturate exactly
        end
        if ($isunknown(s) || (ulp_distance(expected, s) > tol)) begin
            $display("ERROR %s: a=%h b=%h rm=%0d expected %h actual %h",
                     name, x, y, mode, expected, s);
            n_err_val++;
        end
    endtask

    task automatic do_division(input logic [31:0] x, input logic [31:0] y,
                               input logic [1:0] mode, input bit drop_start);
        int n;
        bit got;
        @(posedge clk);
        #2;
        start = 1'b1;
        a     = x;
        b     = y;
        rm    = mode;
        @(posedge clk);                         // start sampled here
        #2;
        start = 1'b0;
        a     = $urandom;                       // captured words must not follow the pins
        b     = $urandom;
        rm    = 2'($urandom);
        n     = 0;
        got   = 1'b0;
        while (!got && (n < LATENCY + 8)) begin
            @(posedge clk);
            #1;
            n++;
            if (done) begin
                got = 1'b1;
            end else if (busy !== 1'b1) begin
                $display("busy low %0d cycles after start while no done yet", n);
                n_err_proto++;
            end
            #1;
            start = drop_start && (n == 3);     // extra start while busy
        end
        if (!got) begin
            $display("no done within %0d cycles of start", LATENCY + 8);
            n_err_proto++;
        end else begin
            if (n != LATENCY) begin
                $display("ERROR done_latency: expected %0d actual %0d", LATENCY, n);
                n_err_lat++;
            end
            if (busy !== 1'b0) begin
                $display("busy still high in the done cycle");
                n_err_proto++;
            end
            check_result(x, y, mode);
            @(posedge clk);
            #1;
            if (done !== 1'b0) begin
                $display("done stayed high for more than one cycle");
                n_err_proto++;
            end
            if (drop_start) begin
                repeat (LATENCY + 2) begin
                    @(posedge clk);
                    #1;
                    if (done !== 1'b0) begin
                        $display("busy_drop: a start that came while busy produced a done");
                        n_err_proto++;
                    end
                end
            end
        end
    endtask

    initial begin
        start       = 1'b0;
        a           = '0;
        b           = '0;
        rm          = 2'b00;
        clrn        = 1'b0;
        n_checks    = 0;
        n_err_val   = 0;
        n_err_lat   = 0;
        n_err_proto = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #2;
        clrn = 1'b1;
        #1;
        if ((done !== 1'b0) || (busy !== 1'b0)) begin
            $display("done or busy not low right after reset");
            n_err_proto++;
        end
        if (s !== 32'h0) begin
            $display("ERROR reset_state: expected %h actual %h", 32'h0, s);
            n_err_val++;
        end
        for (op_idx = 0; op_idx < N_OPS; op_idx++) begin
            pick_operands(op_a, op_b);
            op_rm = 2'($urandom);
            drop  = ($urandom % 8) == 0;
            do_division(op_a, op_b, op_rm, drop);
            repeat ($urandom % 4) @(posedge clk);  // idle gap
        end
        $display("%0d operations, %0d result checks, errors: %0d value, %0d latency, %0d protocol",
                 N_OPS, n_checks, n_err_val, n_err_lat, n_err_proto);
        if ((n_err_val + n_err_lat + n_err_proto) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
